//--- build.f
source/bus_pkg.sv
source/cache_pkg.sv
source/single_port_ram.sv
source/icache_fill_ctrl.sv
source/icache.sv
source/icache_top.sv
verif/mem_model.sv
verif/icache_tb.sv

//--- run.sh
#!/bin/sh
# Build the cache testbench with Verilator, run it and scan the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f build.f --top-module icache_tb -o icache_sim \
	&& ./obj_dir/icache_sim 2>&1 | tee sim.log \
	|| exit 1
test -s sim.log || exit 1
grep -q "TEST FAIL" sim.log && exit 1 || exit 0

//--- source/bus_pkg.sv
`default_nettype none

// Fetch bus and burst memory bus types.
package bus_pkg;

	// ====================
	// Common
	// ====================

	// Byte address on both buses.
	typedef logic [63:0] addr_t;

	// ====================
	// Fetch bus
	// ====================

	// Held by the processor until data_ok is seen.
	typedef struct packed {
		logic valid;
		addr_t addr;
	} ibus_req_t;

	// Data is valid only in the data_ok cycle.
	typedef struct packed {
		logic data_ok;
		logic [31:0] data;
	} ibus_resp_t;

	// ====================
	// Memory bus
	// ====================

	// Read burst of one whole line, 64-bit beats.
	// Valid and addr stay put until the last beat is taken.
	typedef struct packed {
		logic valid;
		addr_t addr;
	} cbus_req_t;

	// One beat per cycle with ready high.
	// Last marks the final beat of the line.
	typedef struct packed {
		logic ready;
		logic last;
		logic [63:0] data;
	} cbus_resp_t;

endpackage

`default_nettype wire

//--- source/cache_pkg.sv
`default_nettype none

// Types shared inside the cache.
package cache_pkg;

	// Refill controller state.
	typedef enum logic {
		idle = 1'b0,
		fill = 1'b1
	} fill_state_t;

	// One data RAM word, the same size as a memory beat.
	typedef logic [63:0] word_t;

	// One instruction, half of a word.
	typedef logic [31:0] inst_t;

endpackage

`default_nettype wire

//--- source/icache.sv
`timescale 1ns/1ns
`default_nettype none

// Direct-mapped read-only instruction cache.
// Hit latency is one cycle, misses refill a whole line.
module icache #(
	parameter int index_bits = 4,
	parameter int offset_bits = 6
) (
	input logic clk,
	input logic reset,
	input bus_pkg::ibus_req_t ireq,
	output bus_pkg::ibus_resp_t iresp,
	output bus_pkg::cbus_req_t creq,
	input bus_pkg::cbus_resp_t cresp
);
	import bus_pkg::*;
	import cache_pkg::*;

	localparam int tag_bits = 64 - index_bits - offset_bits;
	localparam int beat_bits = offset_bits - 3;
	localparam int data_addr_bits = index_bits + beat_bits;

	typedef struct packed {
		logic valid;
		logic [tag_bits-1:0] tag;
	} tag_entry_t;

	logic lookup_pending;
	logic hit;
	logic miss;
	logic busy;
	logic clearing;
	logic data_wen;
	logic tag_wen;
	logic tag_ram_wen;
	logic [beat_bits-1:0] beat;
	logic [index_bits-1:0] clear_index;
	logic [index_bits-1:0] req_index;
	logic [index_bits-1:0] fill_index;
	logic [index_bits-1:0] tag_addr;
	logic [data_addr_bits-1:0] data_addr;
	tag_entry_t tag_wdata;
	tag_entry_t tag_rdata;
	word_t data_rdata;
	inst_t inst;
	addr_t line_addr;

	// ====================
	// RAM addressing
	// ====================

	assign req_index = ireq.addr[offset_bits +: index_bits];
	assign fill_index = creq.addr[offset_bits +: index_bits];
	assign line_addr = {ireq.addr[63:offset_bits], {offset_bits{1'b0}}};

	// Sweep first, then refill, otherwise the request.
	always_comb begin
		if (clearing) begin
			tag_addr = clear_index;
		end else if (busy) begin
			tag_addr = fill_index;
		end else begin
			tag_addr = req_index;
		end
	end

	always_comb begin
		if (clearing) begin
			tag_wdata = '0;
		end else begin
			tag_wdata = '{valid: 1'b1, tag: creq.addr[63 -: tag_bits]};
		end
	end

	assign tag_ram_wen = clearing | tag_wen;

	assign data_addr = busy ? {fill_index, beat} : ireq.addr[offset_bits+index_bits-1:3];

	// ====================
	// Lookup
	// ====================

	// Set for the cycle in which the RAM outputs belong to the request.
	always_ff @(posedge clk) begin
		if (reset) begin
			lookup_pending <= 1'b0;
		end else begin
			lookup_pending <= ireq.valid && !lookup_pending && !busy && !clearing;
		end
	end

	assign hit = tag_rdata.valid && (tag_rdata.tag == ireq.addr[63 -: tag_bits]);
	assign miss = lookup_pending && !hit;

	assign inst = ireq.addr[2] ? data_rdata[63:32] : data_rdata[31:0];
	assign iresp = '{data_ok: lookup_pending && hit, data: inst};

	// ====================
	// Instances
	// ====================

	single_port_ram #(
		.addr_bits(index_bits),
		.payload_t(tag_entry_t)
	) tag_ram (
		.clk(clk),
		.addr(tag_addr),
		.wen(tag_ram_wen),
		.wdata(tag_wdata),
		.rdata(tag_rdata)
	);

	single_port_ram #(
		.addr_bits(data_addr_bits),
		.payload_t(word_t)
	) data_ram (
		.clk(clk),
		.addr(data_addr),
		.wen(data_wen),
		.wdata(cresp.data),
		.rdata(data_rdata)
	);

	icache_fill_ctrl #(
		.index_bits(index_bits),
		.offset_bits(offset_bits)
	) fill_ctrl_i (
		.clk(clk),
		.reset(reset),
		.miss(miss),
		.line_addr(line_addr),
		.cresp(cresp),
		.creq(creq),
		.busy(busy),
		.beat(beat),
		.data_wen(data_wen),
		.tag_wen(tag_wen),
		.clear_index(clear_index),
		.clearing(clearing)
	);

endmodule

`default_nettype wire

//--- source/icache_fill_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

// Refill controller.
// Sweeps the tag RAM after reset, then runs one line burst per miss.
module icache_fill_ctrl #(
	parameter int index_bits = 4,
	parameter int offset_bits = 6
) (
	input logic clk,
	input logic reset,
	input logic miss,
	input bus_pkg::addr_t line_addr,
	input bus_pkg::cbus_resp_t cresp,
	output bus_pkg::cbus_req_t creq,
	output logic busy,
	output logic [offset_bits-4:0] beat,
	output logic data_wen,
	output logic tag_wen,
	output logic [index_bits-1:0] clear_index,
	output logic clearing
);
	import bus_pkg::*;
	import cache_pkg::*;

	fill_state_t state;
	addr_t burst_addr;
	logic beat_ok;

	// ====================
	// Burst request
	// ====================

	assign busy = state == fill;
	assign creq = '{valid: busy, addr: burst_addr};

	// A beat moves whenever memory says ready during a fill.
	assign beat_ok = busy && cresp.ready;
	assign data_wen = beat_ok;
	assign tag_wen = beat_ok && cresp.last;

	// Line address is captured once and held for the whole burst.
	always_ff @(posedge clk) begin
		if (state == idle && miss) begin
			burst_addr <= line_addr;
		end
	end

	// ====================
	// Miss FSM
	// ====================

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			beat <= '0;
		end else begin
			case (state)
				idle: begin
					if (miss) begin
						state <= fill;
						beat <= '0;
					end
				end
				fill: begin
					// Gaps in ready just stall the count.
					if (beat_ok) begin
						beat <= beat + 1'b1;
						if (cresp.last) begin
							state <= idle;
						end
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// ====================
	// Tag sweep
	// ====================

	// One tag entry per cycle, all lines invalid afterwards.
	always_ff @(posedge clk) begin
		if (reset) begin
			clearing <= 1'b1;
			clear_index <= '0;
		end else if (clearing) begin
			clear_index <= clear_index + 1'b1;
			if (&clear_index) begin
				clearing <= 1'b0;
			end
		end
	end

endmodule

`default_nettype wire

//--- source/icache_top.sv
`timescale 1ns/1ns
`default_nettype none

// Cache top level.
// 16 lines of 64 bytes with the default geometry.
module icache_top #(
	parameter int index_bits = 4,
	parameter int offset_bits = 6
) (
	input logic clk,
	input logic reset,
	input bus_pkg::ibus_req_t ireq,
	output bus_pkg::ibus_resp_t iresp,
	output bus_pkg::cbus_req_t creq,
	input bus_pkg::cbus_resp_t cresp
);

	icache #(
		.index_bits(index_bits),
		.offset_bits(offset_bits)
	) icache_i (
		.clk(clk),
		.reset(reset),
		.ireq(ireq),
		.iresp(iresp),
		.creq(creq),
		.cresp(cresp)
	);

endmodule

`default_nettype wire

//--- source/single_port_ram.sv
`timescale 1ns/1ns
`default_nettype none

// Single-port RAM with registered read.
// Write-first: a write shows up on rdata in the next cycle.
module single_port_ram #(
	parameter int addr_bits = 4,
	parameter type payload_t = logic [63:0]
) (
	input logic clk,
	input logic [addr_bits-1:0] addr,
	input logic wen,
	input payload_t wdata,
	output payload_t rdata
);

	localparam int depth = 2 ** addr_bits;

	payload_t mem [depth];

	always_ff @(posedge clk) begin
		if (wen) begin
			mem[addr] <= wdata;
			rdata <= wdata;
		end else begin
			rdata <= mem[addr];
		end
	end

endmodule

`default_nettype wire

//--- verif/icache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module icache_tb;
	import bus_pkg::*;

	localparam int n_random = 48;
	localparam int n_requests = 7 + n_random;
	localparam int max_cycles = n_requests * 40 + 100;
	localparam logic [31:0] seed = 32'h87363ee0;

	typedef enum logic [1:0] {
		expect_any,
		expect_hit,
		expect_miss
	} expect_t;

	logic clk = 1'b1;
	logic reset;
	ibus_req_t ireq;
	ibus_resp_t iresp;
	cbus_req_t creq;
	cbus_resp_t cresp;
	logic [1:0] gap = '0;

	logic [31:0] lfsr;
	addr_t rand_addr [n_random];
	logic [1:0] gap_table [256];
	logic [7:0] gap_pos = '0;

	expect_t expect_kind;
	logic started;
	logic [31:0] expected_inst;
	addr_t expected_line;
	cbus_req_t creq_q;
	logic last_q;
	int beats;
	int bursts;
	int wait_cycles;
	int stalls = 0;
	int cycles = 0;
	int errors = 0;
	int other_errors = 0;
	int error_mark = 0;
	int requests = 0;

	always #10 clk = ~clk;

	icache_top #(
		.index_bits(4),
		.offset_bits(6)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.ireq(ireq),
		.iresp(iresp),
		.creq(creq),
		.cresp(cresp)
	);

	mem_model mem_i (
		.clk(clk),
		.reset(reset),
		.creq(creq),
		.gap(gap),
		.cresp(cresp)
	);

	// ====================
	// Reference model
	// ====================

	// Taps 32, 22, 2, 1.
	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return {state[30:0], state[31] ^ state[21] ^ state[1] ^ state[0]};
	endfunction

	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr = lfsr_next(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] rule_inst(input addr_t addr);
		addr_t aligned;
		logic [63:0] word;
		aligned = {addr[63:3], 3'b000};
		word = (aligned * 64'd3) ^ 64'h0123456789abcdef;
		return addr[2] ? word[63:32] : word[31:0];
	endfunction

	assign expected_inst = rule_inst(ireq.addr);
	assign expected_line = {ireq.addr[63:6], 6'b000000};

	always @(negedge clk) begin
		gap <= gap_table[gap_pos];
		gap_pos <= gap_pos + 1'b1;
	end

	always @(posedge clk) begin
		if (reset) begin
			creq_q <= '0;
			last_q <= 1'b0;
			beats <= 0;
			bursts <= 0;
			wait_cycles <= 0;
		end else begin
			creq_q <= creq;
			last_q <= creq.valid && cresp.ready && cresp.last;
			if (!creq.valid) begin
				beats <= 0;
			end else if (cresp.ready) begin
				beats <= beats + 1;
			end
			if (creq.valid && !cresp.ready) begin
				stalls <= stalls + 1;
			end
			// Per-fetch counters restart between requests.
			if (!ireq.valid) begin
				wait_cycles <= 0;
				bursts <= 0;
			end else begin
				wait_cycles <= wait_cycles + 1;
				if (creq.valid && cresp.ready && cresp.last) begin
					bursts <= bursts + 1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("Run stopped at cycle %0d, the cache did not answer in time", cycles);
			$display("TEST FAIL");
			$finish;
		end
	end

	// ====================
	// Checks
	// ====================

	idle_before_start: assert property (@(posedge clk) disable iff (reset)
		!started |-> !creq.valid && !iresp.data_ok)
	else begin
		errors++;
		$display("Cache raised creq.valid or data_ok before any request");
	end

	inst_data: assert property (@(posedge clk) disable iff (reset)
		iresp.data_ok |-> iresp.data == expected_inst)
	else begin
		errors++;
		$display("ERROR iresp.data got %h expected %h at addr %h",
			$sampled(iresp.data), $sampled(expected_inst), $sampled(ireq.addr));
	end

	line_addr: assert property (@(posedge clk) disable iff (reset)
		creq.valid |-> creq.addr == expected_line)
	else begin
		errors++;
		$display("ERROR creq.addr got %h expected %h",
			$sampled(creq.addr), $sampled(expected_line));
	end

	beat_count: assert property (@(posedge clk) disable iff (reset)
		creq_q.valid && !creq.valid |-> beats == 8)
	else begin
		errors++;
		$display("ERROR beats got %h expected %h", $sampled(beats), 8);
	end

	valid_hold: assert property (@(posedge clk) disable iff (reset)
		creq_q.valid && !last_q |-> creq.valid)
	else begin
		errors++;
		$display("The burst request dropped before its last beat");
	end

	addr_hold: assert property (@(posedge clk) disable iff (reset)
		creq_q.valid && !last_q |-> creq.addr == creq_q.addr)
	else begin
		errors++;
		$display("ERROR creq.addr got %h expected %h",
			$sampled(creq.addr), $sampled(creq_q.addr));
	end

	single_burst: assert property (@(posedge clk) disable iff (reset)
		iresp.data_ok |-> bursts <= 1)
	else begin
		errors++;
		$display("One fetch caused more than one burst");
	end

	hit_latency: assert property (@(posedge clk) disable iff (reset)
		iresp.data_ok && expect_kind == expect_hit |-> wait_cycles == 1)
	else begin
		errors++;
		$display("ERROR wait_cycles got %h expected %h", $sampled(wait_cycles), 1);
	end

	// A burst for a hit would start in the cycle after the compare.
	hit_no_burst: assert property (@(posedge clk) disable iff (reset)
		iresp.data_ok && expect_kind == expect_hit |=> !creq.valid)
	else begin
		errors++;
		$display("A fetch in a filled line started a burst");
	end

	miss_refill: assert property (@(posedge clk) disable iff (reset)
		iresp.data_ok && expect_kind == expect_miss |-> bursts == 1)
	else begin
		errors++;
		$display("A fetch that should miss returned without exactly one refill");
	end

	// ====================
	// Stimulus
	// ====================

	// Called just after a falling edge, returns just after one.
	task automatic fetch(input addr_t addr, input expect_t kind);
		started <= 1'b1;
		expect_kind <= kind;
		ireq <= '{valid: 1'b1, addr: addr};
		do begin
			@(negedge clk);
		end while (!iresp.data_ok);
		// Hold until the data_ok cycle has closed.
		@(negedge clk);
		ireq <= '{valid: 1'b0, addr: '0};
		expect_kind <= expect_any;
		requests++;
		@(negedge clk);
	endtask

	task automatic report_test(input int num, input string name);
		int found;
		found = errors + other_errors - error_mark;
		$display("test %0d %s: %s, %0d errors", num, name, found == 0 ? "ok" : "bad", found);
		error_mark = errors + other_errors;
	endtask

	initial begin
		logic [31:0] bits;
		lfsr = seed;
		for (int i = 0; i < n_random; i++) begin
			take_bits(10, bits);
			rand_addr[i] = {52'd0, bits[9:0], 2'b00};
		end
		for (int i = 0; i < 256; i++) begin
			take_bits(2, bits);
			gap_table[i] = bits[1:0];
		end
		reset = 1'b1;
		ireq = '0;
		started = 1'b0;
		expect_kind = expect_any;

		// The first falling edge comes before any rising edge.
		repeat (3) @(negedge clk);
		reset <= 1'b0;

		// Tag sweep plus some idle time.
		repeat (24) @(negedge clk);
		report_test(1, "idle after reset");

		fetch(64'h0000_0000_0000_1234, expect_miss);
		report_test(2, "first fetch refills");

		fetch(64'h0000_0000_0000_1230, expect_hit);
		fetch(64'h0000_0000_0000_123c, expect_hit);
		report_test(3, "repeat fetch hits");

		// Same index 5, tags differ in the top bit.
		repeat (2) begin
			fetch(64'h0000_0000_0000_0148, expect_miss);
			fetch(64'h8000_0000_0000_0144, expect_miss);
		end
		report_test(4, "conflict eviction");

		for (int i = 0; i < n_random; i++) begin
			fetch(rand_addr[i], expect_any);
		end
		report_test(5, "random fetches");

		if (stalls == 0) begin
			other_errors++;
			$display("No burst ever waited on ready, the hold checks were not exercised");
		end
		report_test(6, "burst hold under back-pressure");

		$display("6 tests, %0d requests, %0d errors", requests, errors + other_errors);
		if (errors + other_errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- verif/mem_model.sv
`timescale 1ns/1ns
`default_nettype none

// Burst memory responder for the cache refill port.
// Every beat returns rule data for its own byte address.
module mem_model (
	input logic clk,
	input logic reset,
	input bus_pkg::cbus_req_t creq,
	input logic [1:0] gap,
	output bus_pkg::cbus_resp_t cresp
);
	import bus_pkg::*;

	logic [2:0] beat;
	logic [1:0] wait_count;

	function automatic logic [63:0] beat_data(input addr_t addr);
		return (addr * 64'd3) ^ 64'h0123456789abcdef;
	endfunction

	// Responses change on the falling edge and are taken on the rising one.
	always @(negedge clk) begin
		logic beat_ready;
		addr_t beat_addr;
		if (reset) begin
			beat = '0;
			wait_count = '0;
			cresp <= '0;
		end else begin
			if (cresp.ready) begin
				// The beat was accepted at the last rising edge.
				beat = beat + 1'b1;
				wait_count = gap;
			end else if (creq.valid && wait_count != 2'd0) begin
				wait_count = wait_count - 1'b1;
			end
			beat_ready = creq.valid && wait_count == 2'd0;
			beat_addr = creq.addr + {58'd0, beat, 3'b000};
			cresp <= '{
				ready: beat_ready,
				last: beat_ready && beat == 3'd7,
				data: beat_ready ? beat_data(beat_addr) : 64'd0
			};
		end
	end

endmodule

`default_nettype wire
